//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = backend_tb
FILELIST  = sources.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
PASS_MSG  = NO ERRORS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- dv/backend_sva.sv
`timescale 1ns/10ps

module backend_sva import backend_pkg::*; (
    input logic     clk,
    input logic     rst_n,
    input logic     instr_valid,
    input logic     wb_valid,
    input reg_idx_t wb_rd,
    input word_t    wb_data
);

    // x0 is never a write-back target
    property no_write_to_x0;
        @(posedge clk) disable iff (!rst_n)
        wb_valid |-> (wb_rd != '0);
    endproperty

    property wb_data_known;
        @(posedge clk) disable iff (!rst_n)
        wb_valid |-> !$isunknown(wb_data);
    endproperty

    // A bubble leaves an empty write-back slot two edges later
    property bubble_gives_no_write;
        @(posedge clk) disable iff (!rst_n)
        !$past(instr_valid, 2) |-> !wb_valid;
    endproperty

    assert property (no_write_to_x0)
        else $error("write-back with rd equal to x0");
    assert property (wb_data_known)
        else $error("write-back data has unknown bits");
    assert property (bubble_gives_no_write)
        else $error("write-back two cycles after a bubble");

endmodule

bind backend_top backend_sva backend_sva_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .wb_valid    (wb_valid),
    .wb_rd       (wb_rd),
    .wb_data     (wb_data)
);

//--- dv/backend_tb.sv
`timescale 1ns/10ps

module backend_tb import backend_pkg::*; ();

    localparam int num_rows    = 54;
    localparam int cycle_limit = 10 + num_rows + 2 + 20;

    typedef struct {
        instr_t   instr;
        logic     valid;
        reg_idx_t rd;
        word_t    data;
        logic     write;
    } row_t;

    typedef struct {
        int       row;
        reg_idx_t rd;
        word_t    data;
        int       sample_edge;
    } expect_t;

    logic        clk;
    logic        rst_n;
    logic        instr_valid;
    word_t       instr;
    logic        wb_valid;
    reg_idx_t    wb_rd;
    word_t       wb_data;

    row_t        rows [num_rows];
    word_t       model_regs [32];
    expect_t     expected_q [$];
    expect_t     got;
    int          errors_before;
    int          row_count   = 0;
    int          cycle_count = 0;
    int          check_count = 0;
    int          error_count = 0;
    int          wb_count    = 0;

    clock_gen clock_gen_inst (.clk (clk), .rst_n (rst_n));

    backend_top backend_top_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data)
    );

    // ============================================================
    // Instruction assembly and reference arithmetic
    // ============================================================

    function automatic instr_t r_type(input logic [6:0] f7, input reg_idx_t rs2,
                                      input reg_idx_t rs1, input logic [2:0] f3,
                                      input reg_idx_t rd);
        instr_t ins;
        ins.r = '{f7, rs2, rs1, f3, rd, op_reg};
        return ins;
    endfunction

    function automatic instr_t i_type(input logic [11:0] imm, input reg_idx_t rs1,
                                      input logic [2:0] f3, input reg_idx_t rd);
        instr_t ins;
        ins.i = '{imm, rs1, f3, rd, op_imm};
        return ins;
    endfunction

    function automatic instr_t u_type(input logic [19:0] imm, input reg_idx_t rd);
        instr_t ins;
        ins.u = '{imm, rd, op_lui};
        return ins;
    endfunction

    // OP-IMM result, b is the sign-extended immediate
    function automatic word_t ref_alu(input logic [2:0] f3, input logic alt,
                                      input word_t a, input word_t b);
        logic [4:0] sh;
        word_t      fill;
        sh   = b[4:0];
        fill = (alt && a[31]) ? ~(32'hffff_ffff >> sh) : 32'h0;
        case (f3)
            3'd0:    return a + b;
            3'd1:    return a << sh;
            3'd2:    return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return (a >> sh) | fill;
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic check_value(input string what, input word_t actual, input word_t expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("error at %0t: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic add_row(input instr_t ins, input logic valid, input logic write,
                           input word_t data);
        rows[row_count] = '{ins, valid, ins.r.rd, data, write};
        if (valid && write) begin
            model_regs[ins.r.rd] = data;
        end
        row_count++;
    endtask

    // ============================================================
    // Stimulus table
    // ============================================================

    task automatic build_table();
        logic [2:0]  f3;
        logic [11:0] imm;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        word_t       rnd;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        // x5 never written
        add_row(r_type(f7_base, 5, 0, f3_add, 1), 1, 1, 32'h0000_0000);
        // Immediate arithmetic
        add_row(u_type(20'h80000, 2), 1, 1, 32'h8000_0000);
        add_row(i_type(12'hffb, 0, f3_add, 3), 1, 1, 32'hffff_fffb);
        add_row(i_type(12'hffc, 3, f3_slt, 4), 1, 1, 32'h0000_0001);
        add_row(i_type(12'hfff, 3, f3_sltu, 5), 1, 1, 32'h0000_0001);
        add_row(i_type(12'h0f0, 3, f3_xor, 6), 1, 1, 32'hffff_ff0b);
        add_row(i_type(12'h123, 0, f3_or, 7), 1, 1, 32'h0000_0123);
        add_row(i_type(12'h7ff, 3, f3_and, 8), 1, 1, 32'h0000_07fb);
        add_row(i_type(12'h004, 7, f3_sll, 9), 1, 1, 32'h0000_1230);
        add_row(i_type(12'h004, 2, f3_srl, 10), 1, 1, 32'h0800_0000);
        add_row(i_type(12'h404, 2, f3_srl, 11), 1, 1, 32'hf800_0000);
        // Register arithmetic
        add_row(r_type(f7_base, 9, 7, f3_add, 12), 1, 1, 32'h0000_1353);
        add_row(r_type(f7_alt, 9, 3, f3_add, 13), 1, 1, 32'hffff_edcb);
        add_row(r_type(f7_base, 9, 7, f3_sll, 14), 1, 1, 32'h0123_0000);
        add_row(r_type(f7_base, 7, 3, f3_slt, 15), 1, 1, 32'h0000_0001);
        add_row(r_type(f7_base, 7, 3, f3_sltu, 16), 1, 1, 32'h0000_0000);
        add_row(r_type(f7_base, 7, 3, f3_xor, 17), 1, 1, 32'hffff_fed8);
        add_row(r_type(f7_base, 8, 2, f3_srl, 18), 1, 1, 32'h0000_0010);
        add_row(r_type(f7_alt, 8, 2, f3_srl, 19), 1, 1, 32'hffff_fff0);
        add_row(r_type(f7_base, 7, 3, f3_or, 20), 1, 1, 32'hffff_fffb);
        add_row(r_type(f7_base, 7, 3, f3_and, 21), 1, 1, 32'h0000_0123);
        // Dependency chains at distance 1, 2 and 3
        add_row(i_type(12'h001, 0, f3_add, 22), 1, 1, 32'h0000_0001);
        add_row(i_type(12'h001, 22, f3_add, 22), 1, 1, 32'h0000_0002);
        add_row(r_type(f7_base, 22, 22, f3_add, 23), 1, 1, 32'h0000_0004);
        add_row(i_type(12'h00a, 0, f3_add, 24), 1, 1, 32'h0000_000a);
        add_row(i_type(12'h014, 0, f3_add, 25), 1, 1, 32'h0000_0014);
        add_row(r_type(f7_base, 25, 24, f3_add, 26), 1, 1, 32'h0000_001e);
        add_row(i_type(12'h007, 0, f3_add, 27), 1, 1, 32'h0000_0007);
        add_row(i_type(12'h008, 0, f3_add, 28), 1, 1, 32'h0000_0008);
        add_row(i_type(12'h009, 0, f3_add, 29), 1, 1, 32'h0000_0009);
        add_row(r_type(f7_alt, 29, 27, f3_add, 30), 1, 1, 32'hffff_fffe);
        // Suppressed writes, then x0 and x4 read back
        add_row(i_type(12'h005, 0, f3_add, 0), 1, 0, 32'h0);
        add_row(r_type(f7_base, 0, 0, f3_add, 1), 1, 1, 32'h0000_0000);
        add_row(instr_t'({12'h005, 5'd1, 3'b000, 5'd2, 7'b0100011}), 1, 0, 32'h0);
        add_row(r_type(7'b0000001, 9, 7, f3_add, 3), 1, 0, 32'h0);
        add_row(i_type(12'h404, 7, f3_sll, 4), 1, 0, 32'h0);
        add_row(i_type(12'h001, 0, f3_add, 5), 0, 0, 32'h0);
        add_row(i_type(12'h003, 4, f3_add, 6), 1, 1, 32'h0000_0004);
        // Random immediates, each row reads the previous result
        rs1 = 5'd6;
        for (int n = 0; n < 16; n++) begin
            rnd = $urandom;
            f3  = n[2:0];
            rd  = reg_idx_t'(1 + (n * 7) % 31);
            imm = rnd[11:0];
            if (f3 == f3_sll) begin
                imm[11:5] = f7_base;
            end
            if (f3 == f3_srl) begin
                imm[11:5] = n[3] ? f7_alt : f7_base;
            end
            add_row(i_type(imm, rs1, f3, rd), 1, 1,
                    ref_alu(f3, (f3 == f3_srl) && imm[10], model_regs[rs1],
                            {{20{imm[11]}}, imm}));
            rs1 = rd;
        end
    endtask

    task automatic finish_run();
        $display("rows %0d, write-backs %0d, checks %0d, errors %0d",
                 num_rows, wb_count, check_count, error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    endtask

    // ============================================================
    // Driver, scoreboard and timeout
    // ============================================================

    initial begin
        expect_t item;
        void'($urandom(12));
        instr_valid = 1'b0;
        instr       = '0;
        build_table();
        @(negedge clk);
        while (!rst_n) begin
            check_value("wb_valid in reset", {31'b0, wb_valid}, 32'h0);
            @(negedge clk);
        end
        for (int i = 0; i < num_rows; i++) begin
            instr       = rows[i].instr;
            instr_valid = rows[i].valid;
            // Sampled at the next rising edge, seen on wb two edges after that
            if (rows[i].valid && rows[i].write) begin
                item = '{i, rows[i].rd, rows[i].data, cycle_count + 3};
                expected_q.push_back(item);
            end
            @(negedge clk);
        end
        instr_valid = 1'b0;
        instr       = '0;
        while (expected_q.size() != 0) begin
            @(negedge clk);
        end
        // Idle cycles to catch stray write-backs
        repeat (4) @(negedge clk);
        finish_run();
    end

    always @(posedge clk) begin
        cycle_count++;
        if (wb_valid === 1'b1) begin
            wb_count++;
            if (expected_q.size() == 0) begin
                error_count++;
                $display("unexpected write-back to x%0d at %0t", wb_rd, $time);
            end else begin
                got           = expected_q.pop_front();
                errors_before = error_count;
                check_value("wb_rd", {27'b0, wb_rd}, {27'b0, got.rd});
                check_value("wb_data", wb_data, got.data);
                check_value("write-back edge", cycle_count, got.sample_edge);
                $display("row %0d: x%0d %s", got.row, got.rd,
                         (error_count == errors_before) ? "passed" : "failed");
            end
        end
    end

    initial begin
        for (int cycles = 0; cycles < cycle_limit; cycles++) begin
            @(posedge clk);
        end
        $display("timeout after %0d cycles, %0d write-backs never arrived",
                 cycle_limit, expected_q.size());
        error_count++;
        finish_run();
    end

endmodule

//--- dv/clock_gen.sv
`timescale 1ns/10ps

module clock_gen (
    output logic clk,
    output logic rst_n
);

    localparam int half_period  = 10;
    localparam int reset_cycles = 10;

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    // Release lands between the two clock edges
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #(half_period / 2);
        rst_n = 1'b1;
    end

endmodule

//--- source/backend_pkg.sv
package backend_pkg;

    // ============================================================
    // Widths
    // ============================================================

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int num_regs   = 1 << reg_addr_w;

    typedef logic [reg_addr_w-1:0] reg_idx_t;
    typedef logic [xlen-1:0]       word_t;

    // ============================================================
    // Opcodes and function fields
    // ============================================================

    typedef enum logic [6:0] {
        op_reg = 7'b0110011,
        op_imm = 7'b0010011,
        op_lui = 7'b0110111
    } opcode_t;

    localparam logic [2:0] f3_add  = 3'b000;
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_srl  = 3'b101;
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    // funct7 for the base op and for sub / sra
    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt  = 7'b0100000;

    // ============================================================
    // ALU operations
    // ============================================================

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b
    } alu_op_t;

    // Three views of one instruction word
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            reg_idx_t   rs2;
            reg_idx_t   rs1;
            logic [2:0] funct3;
            reg_idx_t   rd;
            opcode_t    opcode;
        } r;
        struct packed {
            logic [11:0] imm12;
            reg_idx_t    rs1;
            logic [2:0]  funct3;
            reg_idx_t    rd;
            opcode_t     opcode;
        } i;
        struct packed {
            logic [19:0] imm20;
            reg_idx_t    rd;
            opcode_t     opcode;
        } u;
    } instr_t;

endpackage

//--- source/backend_top.sv
`timescale 1ns/10ps

module backend_top import backend_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     instr_valid,
    input  word_t    instr,
    output logic     wb_valid,
    output reg_idx_t wb_rd,
    output word_t    wb_data
);

    // Operand values from ID/EX
    word_t rs1_data;
    word_t rs2_data;

    // ============================================================
    // Decode and register read, side by side
    // ============================================================

    decode_if dec_bus ();

    instruction_decode instruction_decode_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .dec         (dec_bus.producer)
    );

    // rs1 and rs2 sit at the same bit positions in every kept format
    register_file register_file_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1      (instr[19:15]),
        .rs2      (instr[24:20]),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    // ============================================================
    // Execute and write-back
    // ============================================================

    execute_stage execute_stage_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .dec      (dec_bus.consumer),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data)
    );

endmodule

//--- source/decode_if.sv
`timescale 1ns/10ps

interface decode_if import backend_pkg::*; ();

    logic     valid;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    alu_op_t  alu_op;
    logic     use_imm;
    word_t    imm;
    logic     reg_write;

    // Decoder side
    modport producer (
        output valid, rd, rs1, rs2,
        output alu_op, use_imm, imm, reg_write
    );

    // Execute side
    modport consumer (
        input valid, rd, rs1, rs2,
        input alu_op, use_imm, imm, reg_write
    );

endinterface

//--- source/execute_stage.sv
`timescale 1ns/10ps

module execute_stage import backend_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    decode_if.consumer dec,
    input  word_t      rs1_data,
    input  word_t      rs2_data,
    output logic       wb_valid,
    output reg_idx_t   wb_rd,
    output word_t      wb_data
);

    word_t      op_a;
    word_t      op_rs2;
    word_t      op_b;
    word_t      alu_result;
    logic [4:0] shamt;
    logic       fwd_a;
    logic       fwd_b;

    // ============================================================
    // Forwarding from EX/WB
    // ============================================================

    // Result of the previous instruction is not yet in the register file
    assign fwd_a = wb_valid && (wb_rd == dec.rs1);
    assign fwd_b = wb_valid && (wb_rd == dec.rs2);

    assign op_a   = fwd_a ? wb_data : rs1_data;
    assign op_rs2 = fwd_b ? wb_data : rs2_data;

    // Immediate or register for operand b
    assign op_b  = dec.use_imm ? dec.imm : op_rs2;
    assign shamt = op_b[4:0];

    // ============================================================
    // ALU
    // ============================================================

    always_comb begin
        alu_result = '0;
        case (dec.alu_op)
            alu_add: begin
                alu_result = op_a + op_b;
            end
            alu_sub: begin
                alu_result = op_a - op_b;
            end
            alu_sll: begin
                alu_result = op_a << shamt;
            end
            alu_slt: begin
                alu_result = {{(xlen-1){1'b0}}, ($signed(op_a) < $signed(op_b))};
            end
            alu_sltu: begin
                alu_result = {{(xlen-1){1'b0}}, (op_a < op_b)};
            end
            alu_xor: begin
                alu_result = op_a ^ op_b;
            end
            alu_srl: begin
                alu_result = op_a >> shamt;
            end
            alu_sra: begin
                alu_result = word_t'($signed(op_a) >>> shamt);
            end
            alu_or: begin
                alu_result = op_a | op_b;
            end
            alu_and: begin
                alu_result = op_a & op_b;
            end
            alu_pass_b: begin
                // lui
                alu_result = op_b;
            end
            default: begin
                alu_result = '0;
            end
        endcase
    end

    // ============================================================
    // EX/WB register
    // ============================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= dec.valid && dec.reg_write;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd   <= dec.rd;
        wb_data <= alu_result;
    end

endmodule

//--- source/instruction_decode.sv
`timescale 1ns/10ps

module instruction_decode import backend_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    instr_valid,
    input  instr_t  instr,
    decode_if.producer dec
);

    alu_op_t alu_op_d;
    logic    use_imm_d;
    logic    legal_d;
    logic    funct7_alt;
    word_t   imm_d;

    // funct3 to ALU operation, alt selects sub or sra
    function automatic alu_op_t op_from_funct3(input logic [2:0] funct3, input logic alt);
        alu_op_t op;
        op = alu_add;
        case (funct3)
            f3_add:  op = alt ? alu_sub : alu_add;
            f3_sll:  op = alu_sll;
            f3_slt:  op = alu_slt;
            f3_sltu: op = alu_sltu;
            f3_xor:  op = alu_xor;
            f3_srl:  op = alt ? alu_sra : alu_srl;
            f3_or:   op = alu_or;
            f3_and:  op = alu_and;
        endcase
        return op;
    endfunction

    // In OP-IMM the funct7 position is imm[11:5]
    assign funct7_alt = (instr.r.funct7 == f7_alt);

    // ============================================================
    // Field decode
    // ============================================================

    always_comb begin
        alu_op_d  = alu_add;
        use_imm_d = 1'b0;
        legal_d   = 1'b0;
        imm_d     = {{(xlen-12){instr.i.imm12[11]}}, instr.i.imm12};

        case (instr.r.opcode)
            op_reg: begin
                alu_op_d = op_from_funct3(instr.r.funct3, funct7_alt);
                // Alternate funct7 only exists for sub and sra
                legal_d  = (instr.r.funct7 == f7_base) ||
                           (funct7_alt &&
                            (instr.r.funct3 == f3_add || instr.r.funct3 == f3_srl));
            end
            op_imm: begin
                use_imm_d = 1'b1;
                alu_op_d  = op_from_funct3(instr.i.funct3,
                                           funct7_alt && (instr.i.funct3 == f3_srl));
                case (instr.i.funct3)
                    f3_sll:  legal_d = (instr.r.funct7 == f7_base);
                    f3_srl:  legal_d = (instr.r.funct7 == f7_base) || funct7_alt;
                    default: legal_d = 1'b1;
                endcase
            end
            op_lui: begin
                use_imm_d = 1'b1;
                alu_op_d  = alu_pass_b;
                legal_d   = 1'b1;
                imm_d     = {instr.u.imm20, 12'b0};
            end
            default: begin
                legal_d = 1'b0;
            end
        endcase
    end

    // ============================================================
    // ID/EX register
    // ============================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec.valid     <= 1'b0;
            dec.reg_write <= 1'b0;
            dec.use_imm   <= 1'b0;
            dec.alu_op    <= alu_add;
        end else begin
            dec.valid     <= instr_valid;
            // Illegal encodings and writes to x0 never reach write-back
            dec.reg_write <= legal_d && (instr.r.rd != '0);
            dec.use_imm   <= use_imm_d;
            dec.alu_op    <= alu_op_d;
        end
    end

    always_ff @(posedge clk) begin
        dec.rd  <= instr.r.rd;
        dec.rs1 <= instr.r.rs1;
        dec.rs2 <= instr.r.rs2;
        dec.imm <= imm_d;
    end

endmodule

//--- source/register_file.sv
`timescale 1ns/10ps

module register_file import backend_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    input  logic     wb_valid,
    input  reg_idx_t wb_rd,
    input  word_t    wb_data,
    output word_t    rs1_data,
    output word_t    rs2_data
);

    word_t regs [num_regs];
    word_t rs1_read;
    word_t rs2_read;

    // ============================================================
    // Register array
    // ============================================================

    // Entry 0 is never written, so x0 stays zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_valid) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // ============================================================
    // Read ports
    // ============================================================

    // Write-through for a register written in this same cycle
    assign rs1_read = (wb_valid && (wb_rd == rs1)) ? wb_data : regs[rs1];
    assign rs2_read = (wb_valid && (wb_rd == rs2)) ? wb_data : regs[rs2];

    // ID/EX operand values
    always_ff @(posedge clk) begin
        rs1_data <= rs1_read;
        rs2_data <= rs2_read;
    end

endmodule

//--- sources.f
source/backend_pkg.sv
source/decode_if.sv
source/instruction_decode.sv
source/register_file.sv
source/execute_stage.sv
source/backend_top.sv
dv/clock_gen.sv
dv/backend_sva.sv
dv/backend_tb.sv
